//--- flist.f
source/game_pkg.sv
source/melody_rom.sv
source/tone_generator.sv
source/hexa7seg.sv
source/game_datapath.sv
source/game_control.sv
source/music_game.sv
tb/tb_clock.sv
tb/music_game_assert.sv
tb/tb_music_game.sv

//--- Bender.yml
package:
  name: music_game

sources:
  - source/game_pkg.sv
  - source/melody_rom.sv
  - source/tone_generator.sv
  - source/hexa7seg.sv
  - source/game_datapath.sv
  - source/game_control.sv
  - source/music_game.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/music_game_assert.sv
      - tb/tb_music_game.sv

//--- tb/tb_music_game.sv
`timescale 1ns/1ps

module tb_music_game;

    import game_pkg::*;

    // Low clock frequency so each tone toggles within one lit note
    localparam int unsigned CLOCK_FREQ     = 5_240;
    localparam int unsigned SONG_LEN       = 4;
    localparam int unsigned PLAY_CYCLES    = 20;
    localparam int unsigned TIMEOUT_CYCLES = 200;
    localparam int unsigned MAX_ERRORS     = 3;
    localparam int unsigned CYCLE_LIMIT    = 20_000;
    localparam int unsigned RAND_SEED      = 32'h3efc3772;
    localparam int          MELODY [16]    = '{0, 4, 7, 12, 7, 4, 2, 5, 9, 5, 2, 0, 11, 7, 4, 0};

    logic                clock;
    logic                rst_n;
    logic                iniciar;
    logic [NUM_KEYS-1:0] botoes;
    logic [NUM_KEYS-1:0] leds;
    logic                pulso_buzzer;
    logic                vez_jogador;
    logic                ganhou;
    logic                perdeu;
    logic [6:0]          db_note;
    logic [6:0]          db_round;
    logic [6:0]          db_state;
    int unsigned         error_count = 0;
    int unsigned         check_count = 0;
    int unsigned         cycle_count = 0;

    tb_clock clock_gen (
        .clock ( clock )
    );

    music_game #(
        .CLOCK_FREQ     ( CLOCK_FREQ     ),
        .SONG_LEN       ( SONG_LEN       ),
        .PLAY_CYCLES    ( PLAY_CYCLES    ),
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES ),
        .MAX_ERRORS     ( MAX_ERRORS     )
    ) i_music_game (
        .clock        ( clock        ),
        .rst_n        ( rst_n        ),
        .iniciar      ( iniciar      ),
        .botoes       ( botoes       ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .vez_jogador  ( vez_jogador  ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .db_note      ( db_note      ),
        .db_round     ( db_round     ),
        .db_state     ( db_state     )
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR @ %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [NUM_KEYS-1:0] key_bit(input int note);
        logic [NUM_KEYS-1:0] one_hot;
        one_hot       = '0;
        one_hot[note] = 1'b1;
        return one_hot;
    endfunction

    function automatic int pick_wrong_note(input int right);
        int n;
        n = $urandom % NUM_KEYS;
        if (n == right) begin
            n = (n + 1) % NUM_KEYS;
        end
        return n;
    endfunction

    task automatic start_game();
        @(posedge clock);
        iniciar <= 1'b1;
        @(posedge clock);
        iniciar <= 1'b0;
    endtask

    task automatic press_key(input int note);
        @(posedge clock);
        botoes <= key_bit(note);
        repeat (2) @(posedge clock);
        botoes <= '0;
        @(posedge clock);
    endtask

    // Follows the notes 0 up to rnd, then waits for the player turn
    task automatic watch_playback(input int rnd);
        int lit;
        bit buzzed;
        for (int i = 0; i <= rnd; i++) begin
            @(negedge clock);
            while (leds == '0) @(negedge clock);
            lit    = 0;
            buzzed = 1'b0;
            while (leds != '0) begin
                check_value($sformatf("round %0d note %0d leds", rnd, i), leds,
                            key_bit(MELODY[i]));
                check_value("vez_jogador during playback", vez_jogador, 0);
                if (pulso_buzzer) begin
                    buzzed = 1'b1;
                end
                lit++;
                @(negedge clock);
            end
            check_value($sformatf("round %0d note %0d lit cycles", rnd, i), lit, PLAY_CYCLES);
            check_value("buzzer toggled during note", buzzed, 1);
        end
        while (!vez_jogador) begin
            check_value("leds after last note", leds, 0);
            @(negedge clock);
        end
    endtask

    task automatic play_round(input int rnd);
        watch_playback(rnd);
        for (int i = 0; i <= rnd; i++) begin
            press_key(MELODY[i]);
        end
    endtask

    task automatic play_rounds(input int first);
        for (int r = first; r < SONG_LEN; r++) begin
            play_round(r);
        end
    endtask

    task automatic let_time_run_out();
        @(negedge clock);
        while (vez_jogador) @(negedge clock);
    endtask

    task automatic wait_game_over();
        @(negedge clock);
        while (!ganhou && !perdeu) @(negedge clock);
    endtask

    // Outcome levels must also hold for a while
    task automatic check_outcome(input bit won, input bit lost);
        check_value("ganhou", ganhou, won);
        check_value("perdeu", perdeu, lost);
        check_value("vez_jogador at game end", vez_jogador, 0);
        repeat (10) @(negedge clock);
        check_value("ganhou held", ganhou, won);
        check_value("perdeu held", perdeu, lost);
        check_value("leds at game end", leds, 0);
    endtask

    task automatic test_reset_state();
        @(negedge clock);
        check_value("leds after reset", leds, 0);
        check_value("pulso_buzzer after reset", pulso_buzzer, 0);
        check_value("vez_jogador after reset", vez_jogador, 0);
        check_value("ganhou after reset", ganhou, 0);
        check_value("perdeu after reset", perdeu, 0);
        // Digit 0 on an active-low display
        check_value("db_state after reset", db_state, 7'b1000000);
        check_value("db_round after reset", db_round, 7'b1000000);
        check_value("db_note after reset", db_note, 7'b1000000);
    endtask

    task automatic test_full_game();
        start_game();
        play_rounds(0);
        wait_game_over();
        check_outcome(1'b1, 1'b0);
    endtask

    task automatic test_wrong_press_replay();
        start_game();
        play_round(0);
        watch_playback(1);
        press_key(MELODY[0]);
        press_key(pick_wrong_note(MELODY[1]));
        watch_playback(1);
        press_key(MELODY[0]);
        press_key(MELODY[1]);
        play_rounds(2);
        wait_game_over();
        check_outcome(1'b1, 1'b0);
    endtask

    task automatic test_loss();
        start_game();
        watch_playback(0);
        press_key(pick_wrong_note(MELODY[0]));
        watch_playback(0);
        let_time_run_out();
        watch_playback(0);
        press_key(pick_wrong_note(MELODY[0]));
        wait_game_over();
        check_outcome(1'b0, 1'b1);
    endtask

    task automatic test_restart_after_loss();
        start_game();
        watch_playback(0);
        check_value("perdeu after restart", perdeu, 0);
        press_key(pick_wrong_note(MELODY[0]));
        watch_playback(0);
        press_key(pick_wrong_note(MELODY[0]));
        play_rounds(0);
        wait_game_over();
        check_outcome(1'b1, 1'b0);
    endtask

    initial begin
        int unsigned assert_failures;
        rst_n   = 1'b0;
        iniciar = 1'b0;
        botoes  = '0;
        void'($urandom(RAND_SEED));
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;

        test_reset_state();
        test_full_game();
        test_wrong_press_replay();
        test_loss();
        test_restart_after_loss();

        assert_failures = i_music_game.music_game_checks.failures;
        $display("Closing: %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb/music_game_assert.sv
`timescale 1ns/1ps

module music_game_assert (
    input logic                          clock,
    input logic                          rst_n,
    input logic [game_pkg::NUM_KEYS-1:0] leds,
    input logic                          pulso_buzzer,
    input logic                          vez_jogador,
    input logic                          ganhou,
    input logic                          perdeu
);

    int unsigned failures = 0;

    no_double_outcome: assert property (
        @(posedge clock) disable iff (!rst_n) !(ganhou && perdeu)
    ) else begin
        $error("ganhou and perdeu are high together");
        failures++;
    end

    leds_one_hot: assert property (
        @(posedge clock) disable iff (!rst_n) $onehot0(leds)
    ) else begin
        $error("more than one LED is lit");
        failures++;
    end

    // Player turn never overlaps the note display
    dark_in_player_turn: assert property (
        @(posedge clock) disable iff (!rst_n) vez_jogador |-> (leds == '0)
    ) else begin
        $error("LEDs lit during the player turn");
        failures++;
    end

    quiet_when_dark: assert property (
        @(posedge clock) disable iff (!rst_n) (leds == '0) |-> !pulso_buzzer
    ) else begin
        $error("buzzer high while no LED is lit");
        failures++;
    end

endmodule

bind music_game music_game_assert music_game_checks (.*);

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int unsigned HALF_PERIOD_NS = 4
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

endmodule

//--- source/music_game.sv
`timescale 1ns/1ps

module music_game #(
    parameter int unsigned CLOCK_FREQ     = 50_000_000,
    parameter int unsigned SONG_LEN       = 16,
    parameter int unsigned PLAY_CYCLES    = 25_000_000,
    parameter int unsigned TIMEOUT_CYCLES = 250_000_000,
    parameter int unsigned MAX_ERRORS     = 3
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          iniciar,
    input  logic [game_pkg::NUM_KEYS-1:0] botoes,
    output logic [game_pkg::NUM_KEYS-1:0] leds,
    output logic                          pulso_buzzer,
    output logic                          vez_jogador,
    output logic                          ganhou,
    output logic                          perdeu,
    output logic [6:0]                    db_note,
    output logic [6:0]                    db_round,
    output logic [6:0]                    db_state
);

    import game_pkg::*;

    dp_ctrl_t    ctrl;
    dp_status_t  status;
    game_state_t state;
    note_t       shown_note;
    logic [3:0]  round;

    game_control game_control (
        .clock       ( clock       ),
        .rst_n       ( rst_n       ),
        .iniciar     ( iniciar     ),
        .status      ( status      ),
        .ctrl        ( ctrl        ),
        .vez_jogador ( vez_jogador ),
        .ganhou      ( ganhou      ),
        .perdeu      ( perdeu      ),
        .state       ( state       )
    );

    game_datapath #(
        .CLOCK_FREQ     ( CLOCK_FREQ     ),
        .SONG_LEN       ( SONG_LEN       ),
        .PLAY_CYCLES    ( PLAY_CYCLES    ),
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES ),
        .MAX_ERRORS     ( MAX_ERRORS     )
    ) game_datapath (
        .clock        ( clock        ),
        .rst_n        ( rst_n        ),
        .botoes       ( botoes       ),
        .ctrl         ( ctrl         ),
        .status       ( status       ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .shown_note   ( shown_note   ),
        .round        ( round        )
    );

    // Debug displays
    hexa7seg display_note (
        .hexa    ( shown_note ),
        .display ( db_note    )
    );

    hexa7seg display_round (
        .hexa    ( round    ),
        .display ( db_round )
    );

    hexa7seg display_state (
        .hexa    ( state[3:0] ),
        .display ( db_state   )
    );

endmodule

//--- source/game_control.sv
`timescale 1ns/1ps

module game_control (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   iniciar,
    input  game_pkg::dp_status_t   status,
    output game_pkg::dp_ctrl_t     ctrl,
    output logic                   vez_jogador,
    output logic                   ganhou,
    output logic                   perdeu,
    output game_pkg::game_state_t  state
);

    import game_pkg::*;

    game_state_t next_state;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        ctrl       = '0;
        case (state)
            ST_IDLE, ST_WON, ST_LOST: begin
                if (iniciar) begin
                    ctrl.clr_round  = 1'b1;
                    ctrl.clr_addr   = 1'b1;
                    ctrl.clr_errors = 1'b1;
                    ctrl.clr_timer  = 1'b1;
                    next_state      = ST_PLAY_NOTE;
                end
            end
            ST_PLAY_NOTE: begin
                ctrl.show_note = 1'b1;
                if (status.play_done) begin
                    ctrl.clr_timer = 1'b1;
                    next_state     = ST_PLAY_GAP;
                end
            end
            ST_PLAY_GAP: begin
                if (status.play_done) begin
                    ctrl.clr_timer = 1'b1;
                    // Last note shown, hand over to the player from address 0
                    if (status.last_addr) begin
                        ctrl.clr_addr = 1'b1;
                        next_state    = ST_WAIT_PRESS;
                    end else begin
                        ctrl.inc_addr = 1'b1;
                        next_state    = ST_PLAY_NOTE;
                    end
                end
            end
            ST_WAIT_PRESS: begin
                if (status.press) begin
                    ctrl.clr_timer = 1'b1;
                    next_state     = ST_CHECK;
                end else if (status.timeout) begin
                    ctrl.inc_errors = 1'b1;
                    next_state      = ST_ERROR;
                end
            end
            ST_CHECK: begin
                if (!status.note_ok) begin
                    ctrl.inc_errors = 1'b1;
                    next_state      = ST_ERROR;
                end else if (!status.last_addr) begin
                    ctrl.inc_addr  = 1'b1;
                    ctrl.clr_timer = 1'b1;
                    next_state     = ST_WAIT_PRESS;
                end else if (status.last_round) begin
                    next_state = ST_WON;
                end else begin
                    next_state = ST_NEXT_ROUND;
                end
            end
            ST_NEXT_ROUND: begin
                ctrl.inc_round = 1'b1;
                ctrl.clr_addr  = 1'b1;
                ctrl.clr_timer = 1'b1;
                next_state     = ST_PLAY_NOTE;
            end
            ST_ERROR: begin
                // Error count already updated here
                if (status.errors_full) begin
                    next_state = ST_LOST;
                end else begin
                    ctrl.clr_addr  = 1'b1;
                    ctrl.clr_timer = 1'b1;
                    next_state     = ST_PLAY_NOTE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    assign vez_jogador = (state == ST_WAIT_PRESS) || (state == ST_CHECK);
    assign ganhou      = (state == ST_WON);
    assign perdeu      = (state == ST_LOST);

endmodule

//--- source/game_datapath.sv
`timescale 1ns/1ps

module game_datapath #(
    parameter int unsigned CLOCK_FREQ     = 50_000_000,
    parameter int unsigned SONG_LEN       = 16,
    parameter int unsigned PLAY_CYCLES    = 25_000_000,
    parameter int unsigned TIMEOUT_CYCLES = 250_000_000,
    parameter int unsigned MAX_ERRORS     = 3
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [game_pkg::NUM_KEYS-1:0] botoes,
    input  game_pkg::dp_ctrl_t            ctrl,
    output game_pkg::dp_status_t          status,
    output logic [game_pkg::NUM_KEYS-1:0] leds,
    output logic                          pulso_buzzer,
    output game_pkg::note_t               shown_note,
    output logic [3:0]                    round
);

    import game_pkg::*;

    localparam int unsigned TIMER_MAX = (TIMEOUT_CYCLES > PLAY_CYCLES) ?
                                        TIMEOUT_CYCLES : PLAY_CYCLES;
    localparam int unsigned TW = $clog2(TIMER_MAX + 1);
    localparam int unsigned EW = $clog2(MAX_ERRORS + 1);

    logic [3:0]    addr;
    logic [TW-1:0] timer;
    logic [EW-1:0] errors;
    logic          any_pressed;
    logic          any_pressed_q;
    logic          press_q;
    note_t         captured_note;
    note_t         expected_note;

    function automatic note_t lowest_key(input logic [NUM_KEYS-1:0] keys);
        note_t idx;
        idx = '0;
        for (int k = NUM_KEYS - 1; k >= 0; k--) begin
            if (keys[k]) begin
                idx = note_t'(k);
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clock) begin
        if (!rst_n || ctrl.clr_addr) begin
            addr <= '0;
        end else if (ctrl.inc_addr) begin
            addr <= addr + 4'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || ctrl.clr_round) begin
            round <= '0;
        end else if (ctrl.inc_round) begin
            round <= round + 4'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || ctrl.clr_errors) begin
            errors <= '0;
        end else if (ctrl.inc_errors) begin
            errors <= errors + 1'b1;
        end
    end

    // Saturates so an idle game never wraps
    always_ff @(posedge clock) begin
        if (!rst_n || ctrl.clr_timer) begin
            timer <= '0;
        end else if (timer != TW'(TIMER_MAX)) begin
            timer <= timer + 1'b1;
        end
    end

    // Rising edge of any button
    assign any_pressed = |botoes;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            any_pressed_q <= 1'b0;
            press_q       <= 1'b0;
        end else begin
            any_pressed_q <= any_pressed;
            press_q       <= any_pressed & ~any_pressed_q;
        end
    end

    always_ff @(posedge clock) begin
        if (any_pressed && !any_pressed_q) begin
            captured_note <= lowest_key(botoes);
        end
    end

    // LEDs registered alongside the buzzer
    always_ff @(posedge clock) begin
        if (!rst_n || !ctrl.show_note) begin
            leds <= '0;
        end else begin
            leds <= NUM_KEYS'(1) << expected_note;
        end
    end

    always_comb begin
        status.press       = press_q;
        status.note_ok     = (captured_note == expected_note);
        status.last_addr   = (addr == round);
        status.last_round  = (round == 4'(SONG_LEN - 1));
        status.play_done   = (timer == TW'(PLAY_CYCLES - 1));
        status.timeout     = (timer == TW'(TIMEOUT_CYCLES - 1));
        status.errors_full = (errors >= EW'(MAX_ERRORS));
    end

    assign shown_note = expected_note;

    melody_rom #(
        .SONG_LEN ( SONG_LEN )
    ) melody_rom (
        .addr ( addr          ),
        .note ( expected_note )
    );

    tone_generator #(
        .CLOCK_FREQ ( CLOCK_FREQ )
    ) tone_generator (
        .clock        ( clock          ),
        .rst_n        ( rst_n          ),
        .tone_on      ( ctrl.show_note ),
        .note         ( expected_note  ),
        .pulso_buzzer ( pulso_buzzer   )
    );

endmodule

//--- source/hexa7seg.sv
`timescale 1ns/1ps

module hexa7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    // Segment order gfedcba, a lit segment is 0
    always_comb begin
        case (hexa)
            4'h0:    display = 7'b1000000;
            4'h1:    display = 7'b1111001;
            4'h2:    display = 7'b0100100;
            4'h3:    display = 7'b0110000;
            4'h4:    display = 7'b0011001;
            4'h5:    display = 7'b0010010;
            4'h6:    display = 7'b0000010;
            4'h7:    display = 7'b1111000;
            4'h8:    display = 7'b0000000;
            4'h9:    display = 7'b0010000;
            4'hA:    display = 7'b0001000;
            4'hB:    display = 7'b0000011;
            4'hC:    display = 7'b1000110;
            4'hD:    display = 7'b0100001;
            4'hE:    display = 7'b0000110;
            default: display = 7'b0001110;
        endcase
    end

endmodule

//--- source/tone_generator.sv
`timescale 1ns/1ps

module tone_generator #(
    parameter int unsigned CLOCK_FREQ = 50_000_000
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            tone_on,
    input  game_pkg::note_t note,
    output logic            pulso_buzzer
);

    import game_pkg::*;

    // Lowest note gives the longest half period
    localparam int unsigned HALF_MAX = CLOCK_FREQ / (2 * TONE_HALF_HZ[0]);
    localparam int unsigned CW       = $clog2(HALF_MAX + 1);

    logic [CW-1:0] half_tab [NUM_KEYS];
    logic [CW-1:0] half_count;
    logic [CW-1:0] cnt;

    for (genvar k = 0; k < NUM_KEYS; k++) begin : g_half
        assign half_tab[k] = CW'(CLOCK_FREQ / (2 * TONE_HALF_HZ[k]) - 1);
    end

    assign half_count = (note < 4'(NUM_KEYS)) ? half_tab[note] : half_tab[0];

    always_ff @(posedge clock) begin
        if (!rst_n || !tone_on) begin
            cnt          <= '0;
            pulso_buzzer <= 1'b0;
        end else if (cnt >= half_count) begin
            cnt          <= '0;
            pulso_buzzer <= ~pulso_buzzer;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- source/melody_rom.sv
`timescale 1ns/1ps

module melody_rom #(
    parameter int unsigned SONG_LEN = 16
) (
    input  logic [3:0]      addr,
    output game_pkg::note_t note
);

    import game_pkg::*;

    note_t table_note;

    always_comb begin
        case (addr)
            4'd0:    table_note = 4'd0;
            4'd1:    table_note = 4'd4;
            4'd2:    table_note = 4'd7;
            4'd3:    table_note = 4'd12;
            4'd4:    table_note = 4'd7;
            4'd5:    table_note = 4'd4;
            4'd6:    table_note = 4'd2;
            4'd7:    table_note = 4'd5;
            4'd8:    table_note = 4'd9;
            4'd9:    table_note = 4'd5;
            4'd10:   table_note = 4'd2;
            4'd11:   table_note = 4'd0;
            4'd12:   table_note = 4'd11;
            4'd13:   table_note = 4'd7;
            4'd14:   table_note = 4'd4;
            default: table_note = 4'd0;
        endcase
    end

    // Past the end of a shorter song the table reads as note 0
    assign note = (int'(addr) < SONG_LEN) ? table_note : '0;

endmodule

//--- source/game_pkg.sv
package game_pkg;

    // Buttons, LEDs and note values share one index range
    localparam int unsigned NUM_KEYS = 13;

    typedef logic [3:0] note_t;

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_PLAY_NOTE  = 4'd1,
        ST_PLAY_GAP   = 4'd2,
        ST_WAIT_PRESS = 4'd3,
        ST_CHECK      = 4'd4,
        ST_NEXT_ROUND = 4'd5,
        ST_ERROR      = 4'd6,
        ST_WON        = 4'd7,
        ST_LOST       = 4'd8
    } game_state_t;

    // One-cycle strobes, each acts on the next rising edge
    typedef struct packed {
        logic clr_addr;
        logic inc_addr;
        logic clr_round;
        logic inc_round;
        logic clr_timer;
        logic clr_errors;
        logic inc_errors;
        logic show_note;
    } dp_ctrl_t;

    typedef struct packed {
        logic press;
        logic note_ok;
        logic last_addr;
        logic last_round;
        logic play_done;
        logic timeout;
        logic errors_full;
    } dp_status_t;

    // C4 up to C5, in Hz
    localparam int unsigned TONE_HALF_HZ [NUM_KEYS] = '{
        262, 277, 294, 311, 330, 349, 370,
        392, 415, 440, 466, 494, 523
    };

endpackage
